// File: src/idx_params.svh
`ifndef IDX_PARAMS_SVH
`define IDX_PARAMS_SVH

// op word layout
`define IDX_OP_W        64
`define IDX_OPC_W       4
`define IDX_PE_LSB      4
`define IDX_PE_W        4
`define IDX_BCAST_BIT   8
`define IDX_REG_LSB     9
`define IDX_REG_W       4
`define IDX_ARG_LSB     16

// datapath widths
`define IDX_ADDR_W      48
`define IDX_WORD_W      64
`define IDX_COORD_W     32
`define IDX_WORD_BYTES  8

// response buffering
`define IDX_FIFO_DEPTH  16
`define IDX_FIFO_AFULL  12

`define IDX_PE_ID       0

`endif

// File: src/idx_pkg.sv
`include "idx_params.svh"

package idx_pkg;

    // low nibble of the op word
    typedef enum logic [`IDX_OPC_W-1:0] {
        OP_NOP    = 4'd0,
        OP_RST    = 4'd1,
        OP_LD     = 4'd2,
        OP_STEADY = 4'd3
    } opcode_e;

    typedef enum logic {
        IDLE,
        STEADY
    } ctrl_state_e;

    // targets of OP_LD
    typedef enum logic [`IDX_REG_W-1:0] {
        REG_FETCH_ADDR  = 4'd0,
        REG_FETCH_END   = 4'd1,
        REG_INDEX_COUNT = 4'd2
    } reg_sel_e;

    // code byte bits 1:0
    typedef enum logic [1:0] {
        CODE_NEWLINE = 2'd0,
        CODE_CONST   = 2'd1,
        CODE_FILL2   = 2'd2,
        CODE_FILL3   = 2'd3
    } code_e;

endpackage

// File: src/fetch_ctrl_if.sv
`timescale 1ns/1ns
`include "idx_params.svh"

interface fetch_ctrl_if;
    logic                   start;
    logic                   flush;
    logic [`IDX_ADDR_W-1:0] fetch_addr;
    logic [`IDX_ADDR_W-1:0] fetch_end;
    // address reached end and nothing outstanding
    logic                   fetch_done;

    modport ctrl (
        output start, flush, fetch_addr, fetch_end,
        input  fetch_done
    );

    modport fetch (
        input  start, flush, fetch_addr, fetch_end,
        output fetch_done
    );
endinterface

// File: src/idx_cmd_ctrl.sv
`timescale 1ns/1ns
`include "idx_params.svh"

module idx_cmd_ctrl #(
    parameter int PE_ID = `IDX_PE_ID
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`IDX_OP_W-1:0] op,
    output logic                 busy,
    input  logic                 index_pushed,
    output logic                 index_enable,
    fetch_ctrl_if.ctrl           ctl
);
    import idx_pkg::*;

    ctrl_state_e            state;
    opcode_e                opc;
    reg_sel_e               sel;
    logic                   active;
    logic [`IDX_ADDR_W-1:0] arg;
    logic [`IDX_ADDR_W-1:0] fetch_addr_q;
    logic [`IDX_ADDR_W-1:0] fetch_end_q;
    logic [`IDX_ADDR_W-1:0] index_count;

    // op field decode
    assign opc    = opcode_e'(op[`IDX_OPC_W-1:0]);
    assign sel    = reg_sel_e'(op[`IDX_REG_LSB +: `IDX_REG_W]);
    assign arg    = op[`IDX_ARG_LSB +: `IDX_ADDR_W];
    assign active = op[`IDX_BCAST_BIT] ||
                    (op[`IDX_PE_LSB +: `IDX_PE_W] == PE_ID[`IDX_PE_W-1:0]);

    assign ctl.fetch_addr = fetch_addr_q;
    assign ctl.fetch_end  = fetch_end_q;

    // hold busy through the flush cycle and while responses drain
    assign busy = (state == STEADY) || ctl.flush || !ctl.fetch_done;

    // leftover words of an earlier run may still decode while idle
    // a push already on the output consumes the last count
    assign index_enable = (state == STEADY) && (index_count != '0) &&
                          !(index_count == `IDX_ADDR_W'(1) && index_pushed);

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            ctl.start    <= 1'b0;
            ctl.flush    <= 1'b0;
            fetch_addr_q <= '0;
            fetch_end_q  <= '0;
            index_count  <= '0;
        end else begin
            ctl.start <= 1'b0;
            ctl.flush <= 1'b0;
            if (index_pushed && index_count != '0) begin
                index_count <= index_count - 1'b1;
            end
            // window copy in mem_fetch is stale during the start pulse
            if (state == STEADY && !ctl.start && index_count == '0 && ctl.fetch_done) begin
                state <= IDLE;
            end
            if (active) begin
                case (opc)
                    OP_RST: begin
                        state       <= IDLE;
                        ctl.flush   <= 1'b1;
                        index_count <= '0;
                    end
                    OP_LD: begin
                        case (sel)
                            REG_FETCH_ADDR:  fetch_addr_q <= arg;
                            REG_FETCH_END:   fetch_end_q  <= arg;
                            REG_INDEX_COUNT: index_count  <= arg;
                            default: ;
                        endcase
                    end
                    OP_STEADY: begin
                        // flush clears leftovers of the previous run
                        state     <= STEADY;
                        ctl.start <= 1'b1;
                        ctl.flush <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end
endmodule

// File: src/mem_fetch.sv
`timescale 1ns/1ns
`include "idx_params.svh"

module mem_fetch (
    input  logic                   clk,
    input  logic                   rst,
    fetch_ctrl_if.fetch            ctl,
    output logic                   req_mem_ld,
    output logic [`IDX_ADDR_W-1:0] req_mem_addr,
    input  logic                   req_mem_stall,
    input  logic                   rsp_mem_push,
    input  logic [4:0]             fifo_count,
    input  logic                   fifo_pop
);
    logic [`IDX_ADDR_W-1:0] cur_addr;
    logic [`IDX_ADDR_W-1:0] end_addr;
    logic [4:0]             outstanding;
    logic [5:0]             used;
    logic                   stall_q;
    logic                   issue;

    // requests in flight plus words buffered, less the word leaving now
    assign used = outstanding + fifo_count - fifo_pop;

    assign issue = !ctl.start && !ctl.flush && (cur_addr != end_addr) &&
                   !stall_q && (used < `IDX_FIFO_DEPTH);

    assign ctl.fetch_done = (cur_addr == end_addr) && (outstanding == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_addr    <= '0;
            end_addr    <= '0;
            outstanding <= '0;
            stall_q     <= 1'b0;
            req_mem_ld  <= 1'b0;
        end else begin
            stall_q     <= req_mem_stall;
            req_mem_ld  <= issue;
            outstanding <= outstanding + issue - rsp_mem_push;
            if (ctl.start) begin
                cur_addr <= ctl.fetch_addr;
                end_addr <= ctl.fetch_end;
            end else if (ctl.flush) begin
                // abandon the window, in-flight responses still counted
                cur_addr <= end_addr;
            end else if (issue) begin
                cur_addr <= cur_addr + `IDX_WORD_BYTES;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_mem_addr <= cur_addr;
        end
    end
endmodule

// File: src/rsp_fifo.sv
`timescale 1ns/1ns
`include "idx_params.svh"

module rsp_fifo (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   push,
    input  logic [`IDX_WORD_W-1:0] d,
    input  logic                   pop,
    output logic [`IDX_WORD_W-1:0] q,
    output logic                   empty,
    output logic [4:0]             count,
    output logic                   rsp_mem_stall
);
    localparam int PTR_W = $clog2(`IDX_FIFO_DEPTH);

    logic [`IDX_WORD_W-1:0] mem [`IDX_FIFO_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic                   do_push;
    logic                   do_pop;

    assign empty   = (count == '0);
    assign q       = mem[rd_ptr];
    assign do_push = push && (count < `IDX_FIFO_DEPTH);
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            rsp_mem_stall <= 1'b0;
        end else begin
            wr_ptr        <= wr_ptr + do_push;
            rd_ptr        <= rd_ptr + do_pop;
            count         <= count + do_push - do_pop;
            rsp_mem_stall <= (count >= `IDX_FIFO_AFULL);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= d;
        end
    end
endmodule

// File: src/code_unpacker.sv
`timescale 1ns/1ns
`include "idx_params.svh"

module code_unpacker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   empty,
    input  logic [`IDX_WORD_W-1:0] q,
    output logic                   pop,
    input  logic                   stall_index,
    output logic                   code_valid,
    output idx_pkg::code_e         code,
    output logic [4:0]             delta
);
    import idx_pkg::*;

    localparam int PTR_W = $clog2(`IDX_WORD_BYTES);

    logic [PTR_W-1:0] byte_ptr;
    logic [7:0]       cur_byte;
    logic             last_byte;

    // least significant byte first
    assign cur_byte  = q[{byte_ptr, 3'b000} +: 8];
    assign last_byte = (byte_ptr == PTR_W'(`IDX_WORD_BYTES - 1));

    assign code_valid = !empty && !stall_index && !flush;
    assign code       = code_e'(cur_byte[1:0]);
    // bit 7 carries nothing
    assign delta      = cur_byte[6:2];

    // word leaves the FIFO with its last code
    assign pop = code_valid && last_byte;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            byte_ptr <= '0;
        end else if (code_valid) begin
            byte_ptr <= byte_ptr + 1'b1;
        end
    end
endmodule

// File: src/coord_expander.sv
`timescale 1ns/1ns
`include "idx_params.svh"

module coord_expander (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    code_valid,
    input  idx_pkg::code_e          code,
    input  logic [4:0]              delta,
    input  logic                    index_enable,
    output logic                    index_pushed,
    output logic                    push_index,
    output logic [`IDX_COORD_W-1:0] row,
    output logic [`IDX_COORD_W-1:0] col
);
    import idx_pkg::*;

    assign index_pushed = push_index;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            push_index <= 1'b0;
            row        <= '0;
            col        <= '1;
        end else begin
            push_index <= 1'b0;
            if (code_valid) begin
                case (code)
                    CODE_NEWLINE: begin
                        row <= row + 1'b1;
                        col <= '1;
                    end
                    CODE_CONST: begin
                        // col tracks position even once output is suppressed
                        col        <= col + delta + 1'b1;
                        push_index <= index_enable;
                    end
                    default: ;
                endcase
            end
        end
    end
endmodule

// File: src/idx_decoder_top.sv
`timescale 1ns/1ns
`include "idx_params.svh"

module idx_decoder_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`IDX_OP_W-1:0]    op,
    output logic                    busy,
    output logic                    req_mem_ld,
    output logic [`IDX_ADDR_W-1:0]  req_mem_addr,
    input  logic                    req_mem_stall,
    input  logic                    rsp_mem_push,
    input  logic [`IDX_WORD_W-1:0]  rsp_mem_q,
    output logic                    rsp_mem_stall,
    output logic                    push_index,
    output logic [`IDX_COORD_W-1:0] row,
    output logic [`IDX_COORD_W-1:0] col,
    input  logic                    stall_index
);
    import idx_pkg::*;

    logic                   index_pushed;
    logic                   index_enable;
    logic                   fifo_empty;
    logic                   fifo_pop;
    logic [`IDX_WORD_W-1:0] fifo_q;
    logic [4:0]             fifo_count;
    logic                   code_valid;
    code_e                  code;
    logic [4:0]             delta;

    fetch_ctrl_if ctl_if ();

    idx_cmd_ctrl #(
        .PE_ID(`IDX_PE_ID)
    ) idx_cmd_ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .op           (op),
        .busy         (busy),
        .index_pushed (index_pushed),
        .index_enable (index_enable),
        .ctl          (ctl_if.ctrl)
    );

    mem_fetch mem_fetch_inst (
        .clk           (clk),
        .rst           (rst),
        .ctl           (ctl_if.fetch),
        .req_mem_ld    (req_mem_ld),
        .req_mem_addr  (req_mem_addr),
        .req_mem_stall (req_mem_stall),
        .rsp_mem_push  (rsp_mem_push),
        .fifo_count    (fifo_count),
        .fifo_pop      (fifo_pop)
    );

    rsp_fifo rsp_fifo_inst (
        .clk           (clk),
        .rst           (rst),
        .flush         (ctl_if.flush),
        .push          (rsp_mem_push),
        .d             (rsp_mem_q),
        .pop           (fifo_pop),
        .q             (fifo_q),
        .empty         (fifo_empty),
        .count         (fifo_count),
        .rsp_mem_stall (rsp_mem_stall)
    );

    code_unpacker code_unpacker_inst (
        .clk         (clk),
        .rst         (rst),
        .flush       (ctl_if.flush),
        .empty       (fifo_empty),
        .q           (fifo_q),
        .pop         (fifo_pop),
        .stall_index (stall_index),
        .code_valid  (code_valid),
        .code        (code),
        .delta       (delta)
    );

    coord_expander coord_expander_inst (
        .clk          (clk),
        .rst          (rst),
        .flush        (ctl_if.flush),
        .code_valid   (code_valid),
        .code         (code),
        .delta        (delta),
        .index_enable (index_enable),
        .index_pushed (index_pushed),
        .push_index   (push_index),
        .row          (row),
        .col          (col)
    );
endmodule

// File: tb/idx_decoder_asserts.sv
`timescale 1ns/1ns

module idx_decoder_asserts (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic req_mem_ld,
    input logic req_mem_stall,
    input logic push_index
);
    // output only inside a run
    push_in_run: assert property (@(posedge clk) disable iff (rst) push_index |-> busy)
        else $error("push_index while busy is low");

    // stall is registered, so a request reacts two edges later
    req_after_stall: assert property (@(posedge clk) disable iff (rst)
        req_mem_ld |-> !$past(req_mem_stall, 2))
        else $error("req_mem_ld issued while the registered req_mem_stall was high");
endmodule

bind idx_decoder_top idx_decoder_asserts idx_decoder_asserts_inst (
    .clk           (clk),
    .rst           (rst),
    .busy          (busy),
    .req_mem_ld    (req_mem_ld),
    .req_mem_stall (req_mem_stall),
    .push_index    (push_index)
);

// File: tb/idx_decoder_tb.sv
`timescale 1ns/1ns

module idx_decoder_tb;
    import idx_pkg::*;

    localparam int MEM_WORDS       = 64;
    // words fetched over all runs below
    localparam int FETCH_WORDS     = 112;
    localparam int WATCHDOG_CYCLES = 200 * FETCH_WORDS + 1000;

    logic        clk;
    logic        rst;
    logic [63:0] op;
    logic        busy;
    logic        req_mem_ld;
    logic [47:0] req_mem_addr;
    logic        req_mem_stall;
    logic        rsp_mem_push;
    logic [63:0] rsp_mem_q;
    logic        rsp_mem_stall;
    logic        push_index;
    logic [31:0] row;
    logic [31:0] col;
    logic        stall_index;

    logic [63:0] mem [MEM_WORDS];
    logic [15:0] lfsr;
    // expected {row, col} of every push in the current run
    logic [63:0] exp_q [$];
    int          push_idx;
    int          run_id;
    logic [47:0] win_start;
    logic [47:0] win_end;
    logic [47:0] next_addr;
    logic        random_mode;
    logic        saw_rsp_stall;

    idx_decoder_top idx_decoder_top_inst (
        .clk           (clk),
        .rst           (rst),
        .op            (op),
        .busy          (busy),
        .req_mem_ld    (req_mem_ld),
        .req_mem_addr  (req_mem_addr),
        .req_mem_stall (req_mem_stall),
        .rsp_mem_push  (rsp_mem_push),
        .rsp_mem_q     (rsp_mem_q),
        .rsp_mem_stall (rsp_mem_stall),
        .push_index    (push_index),
        .row           (row),
        .col           (col),
        .stall_index   (stall_index)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois LFSR, one step per bit
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return bits;
    endfunction

    // returns {push, row, col} after one code byte
    function automatic logic [64:0] ref_coord(input logic [63:0] rc, input logic [7:0] code_byte);
        logic [31:0] r;
        logic [31:0] c;
        logic        hit;
        r   = rc[63:32];
        c   = rc[31:0];
        hit = 1'b0;
        case (code_byte[1:0])
            // newline
            2'd0: begin
                r = r + 32'd1;
                c = '1;
            end
            // constant delta
            2'd1: begin
                c   = c + 32'(code_byte[6:2]) + 32'd1;
                hit = 1'b1;
            end
            default: ;
        endcase
        return {hit, r, c};
    endfunction

    function automatic logic [63:0] make_op(input logic [3:0] opc, input logic [3:0] sel,
                                            input logic [47:0] arg, input logic [3:0] pe,
                                            input logic bcast);
        return {arg, 3'b000, sel, bcast, pe, opc};
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic send_op(input logic [63:0] value);
        op = value;
        @(posedge clk);
        #10;
        op = '0;
    endtask

    task automatic wait_idle();
        do begin
            @(posedge clk);
            #10;
        end while (busy);
    endtask

    // reference walk over the window, then load the registers
    task automatic load_run(input int first, input int words, input int limit);
        logic [63:0] rc;
        logic [64:0] step;
        int          pushes;
        rc     = {32'd0, 32'hFFFF_FFFF};
        pushes = 0;
        exp_q.delete();
        for (int w = first; w < first + words; w++) begin
            for (int b = 0; b < 8; b++) begin
                step = ref_coord(rc, mem[w][8*b +: 8]);
                rc   = step[63:0];
                if (step[64] && (limit < 0 || pushes < limit)) begin
                    exp_q.push_back(rc);
                    pushes++;
                end
            end
        end
        win_start = 48'(first * 8);
        win_end   = 48'((first + words) * 8);
        run_id++;
        send_op(make_op(OP_LD, REG_FETCH_ADDR, win_start, 4'd0, 1'b0));
        send_op(make_op(OP_LD, REG_FETCH_END, win_end, 4'd0, 1'b1));
        send_op(make_op(OP_LD, REG_INDEX_COUNT, 48'(pushes), 4'd0, 1'b0));
    endtask

    task automatic run_steady();
        send_op(make_op(OP_STEADY, 4'd0, 48'd0, 4'd0, 1'b1));
        check("busy", 64'(busy), 64'd1);
        wait_idle();
        check("push_index count", 64'(push_idx), 64'(exp_q.size()));
        check("req_mem_addr end", 64'(next_addr), 64'(win_end));
    endtask

    // memory model and random stalls
    initial begin
        logic [47:0] pend_addr [$];
        int          pend_due [$];
        logic [5:0]  widx;
        int          cycle;
        int          due;
        int          last_due;
        int          seen_run;
        rsp_mem_push  = 1'b0;
        rsp_mem_q     = '0;
        stall_index   = 1'b0;
        req_mem_stall = 1'b0;
        saw_rsp_stall = 1'b0;
        next_addr     = '0;
        cycle         = 0;
        last_due      = 0;
        seen_run      = 0;
        lfsr          = 16'd51;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = take_bits(64);
        end
        forever begin
            @(posedge clk);
            #10;
            cycle++;
            if (run_id != seen_run) begin
                next_addr = win_start;
                seen_run  = run_id;
            end
            if (req_mem_ld) begin
                check("req_mem_addr", 64'(req_mem_addr), 64'(next_addr));
                if (next_addr >= win_end) begin
                    report_failure("memory request past the end of the fetch window");
                end else begin
                    next_addr = next_addr + 48'd8;
                    // 1 to 4 cycles, never overtaking an older request
                    due = cycle + 1 + int'(take_bits(2));
                    if (due < last_due) begin
                        due = last_due;
                    end
                    last_due = due;
                    pend_addr.push_back(req_mem_addr);
                    pend_due.push_back(due);
                end
            end
            rsp_mem_push = 1'b0;
            if (rsp_mem_stall) begin
                saw_rsp_stall = 1'b1;
            end
            if (pend_addr.size() != 0 && pend_due[0] <= cycle && !rsp_mem_stall) begin
                widx = pend_addr[0][8:3];
                void'(pend_addr.pop_front());
                void'(pend_due.pop_front());
                rsp_mem_push = 1'b1;
                rsp_mem_q    = mem[widx];
            end
            if (random_mode) begin
                stall_index   = (take_bits(2) != 64'd0);
                req_mem_stall = (take_bits(2) == 64'd0);
            end else begin
                stall_index   = 1'b0;
                req_mem_stall = 1'b0;
            end
        end
    end

    // compare each push against the reference
    initial begin
        int seen_run;
        seen_run = 0;
        push_idx = 0;
        forever begin
            @(negedge clk);
            if (run_id != seen_run) begin
                push_idx = 0;
                seen_run = run_id;
            end
            if (push_index) begin
                if (push_idx >= exp_q.size()) begin
                    report_failure("push_index seen with no index left in the reference");
                end else begin
                    check("row", 64'(row), 64'(exp_q[push_idx][63:32]));
                    check("col", 64'(col), 64'(exp_q[push_idx][31:0]));
                    push_idx++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 100);
        report_failure("watchdog expired before all runs finished");
    end

    initial begin
        int half;
        rst         = 1'b1;
        op          = '0;
        random_mode = 1'b0;
        run_id      = 0;
        win_start   = '0;
        win_end     = '0;
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b0;

        check("busy", 64'(busy), 64'd0);
        check("req_mem_ld", 64'(req_mem_ld), 64'd0);
        check("rsp_mem_stall", 64'(rsp_mem_stall), 64'd0);
        check("push_index", 64'(push_index), 64'd0);
        check("row", 64'(row), 64'd0);
        check("col", 64'(col), 64'hFFFF_FFFF);

        // count load aimed at PE 5 must be ignored
        load_run(0, 8, 0);
        send_op(make_op(OP_LD, REG_INDEX_COUNT, 48'd5, 4'd5, 1'b0));
        run_steady();

        load_run(8, 16, -1);
        run_steady();

        random_mode = 1'b1;
        load_run(24, 32, -1);
        run_steady();
        check("rsp_mem_stall seen", 64'(saw_rsp_stall), 64'd1);

        // fewer indices than constant codes
        load_run(0, 16, 5);
        run_steady();

        // soft reset halfway through a run
        load_run(32, 32, -1);
        send_op(make_op(OP_STEADY, 4'd0, 48'd0, 4'd0, 1'b1));
        half = exp_q.size() / 2;
        while (push_idx < half) begin
            @(posedge clk);
            #10;
        end
        send_op(make_op(OP_RST, 4'd0, 48'd0, 4'd0, 1'b1));
        wait_idle();

        // next run starts again at row 0
        load_run(56, 8, -1);
        run_steady();

        $display("Simulation completed successfully");
        $finish;
    end
endmodule

// File: build.f
+incdir+src
src/idx_pkg.sv
src/fetch_ctrl_if.sv
src/idx_cmd_ctrl.sv
src/mem_fetch.sv
src/rsp_fifo.sv
src/code_unpacker.sv
src/coord_expander.sv
src/idx_decoder_top.sv
tb/idx_decoder_asserts.sv
tb/idx_decoder_tb.sv

// File: run.sh
#!/usr/bin/env bash
verilator --binary --assert --top-module idx_decoder_tb -f build.f -o idx_decoder_sim \
    && ./obj_dir/idx_decoder_sim | tee /dev/stderr \
        | grep -q "Simulation completed successfully" \
    && echo "PASS" \
    || { echo "FAIL: pass message not found"; exit 1; }
